// File: src/ball_link_pkg.sv
`default_nettype none

package ball_link_pkg;

    // address byte plus y high, y low and vy
    parameter int FRAME_BYTES = 4;

    // payload carried with the send request
    typedef struct packed {
        logic [9:0] y;   // ball row
        logic [7:0] vy;  // signed velocity
    } ball_state_t;

    // operation asked of the byte engine
    typedef enum logic [1:0] {
        CMD_START = 2'd0,
        CMD_WRITE = 2'd1,
        CMD_STOP  = 2'd2
    } i2c_cmd_e;

    typedef struct packed {
        i2c_cmd_e   op;
        logic [7:0] data;  // ignored for start/stop
    } i2c_cmd_t;

    // valid while send_ack is high
    typedef struct packed {
        logic       nack;
        logic [2:0] bytes_sent;  // acked bytes, address included
    } link_status_t;

endpackage

`default_nettype wire

// File: src/ball_frame_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module ball_frame_sequencer #(
    parameter logic [6:0] SLAVE_ADDR = 7'h55
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         send_req,
    input  ball_link_pkg::ball_state_t   ball,
    input  logic                         ready,
    input  logic                         byte_done,
    input  logic                         ack_ok,
    output logic                         send_ack,
    output ball_link_pkg::link_status_t  status,
    output ball_link_pkg::i2c_cmd_t      cmd,
    output logic                         cmd_en
);
    import ball_link_pkg::*;

    typedef enum logic [3:0] {
        S_IDLE,
        S_LATCH,
        S_ISSUE_START,
        S_WAIT_READY,
        S_ISSUE_BYTE,
        S_WAIT_BYTE,
        S_ISSUE_STOP,
        S_WAIT_STOP,
        S_ACK_HOLD
    } state_t;

    state_t      state;
    ball_state_t ball_q;
    logic [1:0]  byte_idx;
    logic [2:0]  sent_cnt;
    logic        nack_q;
    logic [7:0]  next_byte;

    assign status = '{nack: nack_q, bytes_sent: sent_cnt};

    always_comb begin
        case (byte_idx)
            2'd0:    next_byte = {SLAVE_ADDR, 1'b0};  // write
            2'd1:    next_byte = {ball_q.y[9:8], 6'b0};
            2'd2:    next_byte = ball_q.y[7:0];
            default: next_byte = ball_q.vy;
        endcase
    end

    // payload regs
    always_ff @(posedge clk) begin
        if (state == S_LATCH)
            ball_q <= ball;
        if (ready) begin
            case (state)
                S_ISSUE_START: cmd <= '{op: CMD_START, data: 8'h00};
                S_ISSUE_BYTE:  cmd <= '{op: CMD_WRITE, data: next_byte};
                S_ISSUE_STOP:  cmd <= '{op: CMD_STOP, data: 8'h00};
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= S_IDLE;
            cmd_en   <= 1'b0;
            send_ack <= 1'b0;
            byte_idx <= '0;
            sent_cnt <= '0;
            nack_q   <= 1'b0;
        end else begin
            cmd_en <= 1'b0;  // single-clock strobe
            case (state)
                S_IDLE: if (send_req) state <= S_LATCH;
                S_LATCH: begin
                    byte_idx <= '0;
                    sent_cnt <= '0;
                    nack_q   <= 1'b0;
                    state    <= S_ISSUE_START;
                end
                S_ISSUE_START: if (ready) begin
                    cmd_en <= 1'b1;
                    state  <= S_WAIT_READY;
                end
                // ready only drops the clock after cmd_en
                S_WAIT_READY: if (!cmd_en && ready) state <= S_ISSUE_BYTE;
                S_ISSUE_BYTE: if (ready) begin
                    cmd_en <= 1'b1;
                    state  <= S_WAIT_BYTE;
                end
                S_WAIT_BYTE: if (byte_done) begin
                    if (!ack_ok) begin
                        nack_q <= 1'b1;  // abort rest of frame
                        state  <= S_ISSUE_STOP;
                    end else begin
                        sent_cnt <= sent_cnt + 3'd1;
                        if (byte_idx == 2'(FRAME_BYTES - 1)) begin
                            state <= S_ISSUE_STOP;
                        end else begin
                            byte_idx <= byte_idx + 2'd1;
                            state    <= S_ISSUE_BYTE;
                        end
                    end
                end
                S_ISSUE_STOP: if (ready) begin
                    cmd_en <= 1'b1;
                    state  <= S_WAIT_STOP;
                end
                S_WAIT_STOP: if (!cmd_en && ready) begin
                    send_ack <= 1'b1;
                    state    <= S_ACK_HOLD;
                end
                S_ACK_HOLD: if (!send_req) begin
                    send_ack <= 1'b0;
                    state    <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // engine must be free whenever a command is strobed
    a_cmd_en_ready: assert property (@(posedge clk) disable iff (reset)
        cmd_en |-> ready);

endmodule

`default_nettype wire

// File: src/i2c_byte_master.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_byte_master #(
    parameter int CLK_DIV = 4
) (
    input  logic                     clk,
    input  logic                     reset,
    input  ball_link_pkg::i2c_cmd_t  cmd,
    input  logic                     cmd_en,
    input  logic                     sda_in,
    output logic                     ready,
    output logic                     byte_done,
    output logic                     ack_ok,
    output logic                     scl,
    output logic                     sda_oe
);
    import ball_link_pkg::*;

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;  // clocks within a quarter
    logic [1:0]       phase;    // quarter of the scl period
    logic [3:0]       bit_cnt;  // 0..7 data, 8 ack
    logic [6:0]       shift;    // bits still to send after the msb
    i2c_cmd_e         op_q;
    logic             tick;
    logic             last_bit;

    assign tick     = (div_cnt == DIV_W'(CLK_DIV - 1));
    assign last_bit = (op_q != CMD_WRITE) || (bit_cnt == 4'd8);

    // outputs change on quarter boundaries only
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ready     <= 1'b1;
            byte_done <= 1'b0;
            ack_ok    <= 1'b0;
            scl       <= 1'b1;
            sda_oe    <= 1'b0;
            div_cnt   <= '0;
            phase     <= '0;
            bit_cnt   <= '0;
            op_q      <= CMD_START;
        end else begin
            byte_done <= 1'b0;
            if (ready) begin
                if (cmd_en) begin
                    ready   <= 1'b0;
                    op_q    <= cmd.op;
                    div_cnt <= '0;
                    phase   <= '0;
                    bit_cnt <= '0;
                    // first quarter of the operation
                    case (cmd.op)
                        CMD_START: begin
                            scl    <= 1'b1;
                            sda_oe <= 1'b0;
                        end
                        CMD_WRITE: begin
                            scl    <= 1'b0;
                            sda_oe <= ~cmd.data[7];  // msb first
                        end
                        default: begin
                            scl    <= 1'b0;
                            sda_oe <= 1'b1;  // hold sda low before stop
                        end
                    endcase
                end
            end else if (tick) begin
                div_cnt <= '0;
                phase   <= phase + 2'd1;
                if (phase == 2'd3) begin
                    if (last_bit) begin
                        ready     <= 1'b1;
                        byte_done <= (op_q == CMD_WRITE);
                    end else begin
                        // next bit while scl stays low
                        bit_cnt <= bit_cnt + 4'd1;
                        sda_oe  <= (bit_cnt == 4'd7) ? 1'b0 : ~shift[6];
                    end
                end else begin
                    case (op_q)
                        CMD_START: begin
                            scl    <= (phase != 2'd2);
                            sda_oe <= 1'b1;  // falls while scl high
                        end
                        CMD_WRITE: begin
                            scl <= (phase != 2'd2);
                            if (bit_cnt == 4'd8 && phase == 2'd1)
                                ack_ok <= ~sda_in;  // mid-high sample
                        end
                        default: begin
                            scl    <= 1'b1;
                            sda_oe <= (phase == 2'd0);  // rises in quarter 2
                        end
                    endcase
                end
            end else begin
                div_cnt <= div_cnt + DIV_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ready && cmd_en)
            shift <= cmd.data[6:0];
        else if (!ready && tick && phase == 2'd3 && !last_bit)
            shift <= {shift[5:0], 1'b0};
    end

    // data bits may only move while scl is low
    a_sda_stable: assert property (@(posedge clk) disable iff (reset)
        (scl && $past(scl) && (sda_oe != $past(sda_oe))) |-> (op_q != CMD_WRITE));

endmodule

`default_nettype wire

// File: src/ball_link_top.sv
`timescale 1ns/1ps
`default_nettype none

module ball_link_top #(
    parameter logic [6:0] SLAVE_ADDR = 7'h55,
    parameter int         CLK_DIV    = 4
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         send_req,
    input  ball_link_pkg::ball_state_t   ball,
    input  logic                         sda_in,
    output logic                         send_ack,
    output ball_link_pkg::link_status_t  status,
    output logic                         scl,
    output logic                         sda_oe
);
    import ball_link_pkg::*;

    i2c_cmd_t cmd;
    logic     cmd_en;
    logic     ready;
    logic     byte_done;
    logic     ack_ok;

    ball_frame_sequencer #(
        .SLAVE_ADDR (SLAVE_ADDR)
    ) u_seq (
        .clk       (clk),
        .reset     (reset),
        .send_req  (send_req),
        .ball      (ball),
        .ready     (ready),
        .byte_done (byte_done),
        .ack_ok    (ack_ok),
        .send_ack  (send_ack),
        .status    (status),
        .cmd       (cmd),
        .cmd_en    (cmd_en)
    );

    i2c_byte_master #(
        .CLK_DIV (CLK_DIV)
    ) u_i2c (
        .clk       (clk),
        .reset     (reset),
        .cmd       (cmd),
        .cmd_en    (cmd_en),
        .sda_in    (sda_in),
        .ready     (ready),
        .byte_done (byte_done),
        .ack_ok    (ack_ok),
        .scl       (scl),
        .sda_oe    (sda_oe)
    );

endmodule

`default_nettype wire

// File: test/i2c_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_slave_model (
    input  logic            clk,
    input  logic            reset,
    input  logic            scl,
    input  logic            sda,
    input  logic [2:0]      nack_at,     // 1-based byte to refuse, 0 acks all
    output logic            sda_drive,
    output logic [7:0][7:0] rx_bytes,
    output logic [3:0]      rx_count,
    output logic [7:0]      frame_count,
    output logic            frame_done
);
    logic       scl_p;
    logic       sda_p;
    logic [3:0] bit_cnt;
    logic [7:0] shift;
    logic       ack_phase;  // between 8th falling edge and end of ack clock

    // bus sampled on the system clock, edges seen one clock late
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            scl_p       <= 1'b1;
            sda_p       <= 1'b1;
            sda_drive   <= 1'b0;
            rx_bytes    <= '0;
            rx_count    <= '0;
            frame_count <= '0;
            frame_done  <= 1'b0;
            bit_cnt     <= '0;
            shift       <= '0;
            ack_phase   <= 1'b0;
        end else begin
            scl_p <= scl;
            sda_p <= sda;
            if (scl && scl_p && sda_p && !sda) begin
                bit_cnt     <= '0;  // start
                ack_phase   <= 1'b0;
                rx_count    <= '0;
                frame_done  <= 1'b0;
                frame_count <= frame_count + 8'd1;
            end else if (scl && scl_p && !sda_p && sda) begin
                frame_done <= 1'b1;  // stop
            end else if (scl && !scl_p && bit_cnt < 4'd8) begin
                shift   <= {shift[6:0], sda};
                bit_cnt <= bit_cnt + 4'd1;
            end else if (!scl && scl_p) begin
                if (ack_phase) begin
                    sda_drive <= 1'b0;  // release after ack clock
                    ack_phase <= 1'b0;
                    bit_cnt   <= '0;
                end else if (bit_cnt == 4'd8) begin
                    rx_bytes[rx_count[2:0]] <= shift;
                    rx_count  <= rx_count + 4'd1;
                    sda_drive <= (4'(nack_at) != rx_count + 4'd1);
                    ack_phase <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: test/tb_ball_link.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ball_link;
    import ball_link_pkg::*;

    localparam logic [6:0] SLAVE_ADDR = 7'h55;
    localparam int         CLK_DIV    = 4;
    localparam int         MAX_TESTS  = 32;
    localparam int         TEST_CLKS  = 6 * 36 * CLK_DIV + 200;  // budget per request

    logic            clk = 1'b0;
    logic            reset;
    logic            send_req;
    ball_state_t     ball;
    logic            send_ack;
    link_status_t    status;
    logic            scl;
    logic            sda_oe;
    logic            sda_drive;
    logic            sda;
    logic [2:0]      nack_at;
    logic [7:0][7:0] rx_bytes;
    logic [3:0]      rx_count;
    logic [7:0]      frame_count;
    logic            frame_done;
    logic [15:0]     vectors [0:3*MAX_TESTS-1];  // y, vy, nack_at per test
    int              num_tests = 0;
    int              failed_tests = 0;
    int              errors = 0;

    assign sda = ~(sda_oe | sda_drive);  // pull-up

    always #4 clk = ~clk;

    ball_link_top #(
        .SLAVE_ADDR (SLAVE_ADDR),
        .CLK_DIV    (CLK_DIV)
    ) DUT (
        .sda_in (sda),
        .*
    );

    i2c_slave_model slave (.*);

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_status(input link_status_t got, input link_status_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: status got nack=%b bytes_sent=%0d expected %s",
                     $time, got.nack, got.bytes_sent,
                     $sformatf("nack=%b bytes_sent=%0d", exp.nack, exp.bytes_sent));
            errors++;
        end
    endtask

    task automatic check_frame_len(input int got, input int exp);
        if (got != exp) begin
            $display("MISMATCH at %0t ns: rx_count got %0d expected %0d", $time, got, exp);
            errors++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic run_frame(input int t);
        ball_state_t  b;
        logic [2:0]   k;
        logic [7:0]   exp_bytes [FRAME_BYTES];
        link_status_t exp_status;
        logic [7:0]   frames_before;
        int           exp_len;
        int           waited;
        int           errors_before;
        int           i;
        b = '{y: vectors[3*t][9:0], vy: vectors[3*t+1][7:0]};
        k = vectors[3*t+2][2:0];
        exp_bytes[0] = {SLAVE_ADDR, 1'b0};  // write
        exp_bytes[1] = {b.y[9:8], 6'b0};
        exp_bytes[2] = b.y[7:0];
        exp_bytes[3] = b.vy;
        exp_len = (k == 3'd0) ? FRAME_BYTES : int'(k);
        exp_status.nack = (k != 3'd0);
        exp_status.bytes_sent = (k == 3'd0) ? 3'(FRAME_BYTES) : k - 3'd1;
        errors_before = errors;
        repeat ($urandom_range(20, 0)) @(negedge clk);
        nack_at = k;
        ball = b;
        frames_before = frame_count;
        send_req = 1'b1;
        waited = 0;
        while (send_ack !== 1'b1 && waited < TEST_CLKS) begin
            @(negedge clk);
            waited++;
        end
        if (send_ack !== 1'b1) begin
            report_failure("send_ack never rose after send_req was raised");
        end else begin
            check_bit("frame_done", frame_done, 1'b1);  // stop seen before ack
            check_status(status, exp_status);
            check_frame_len(int'(rx_count), exp_len);
            for (i = 0; i < exp_len; i++)
                check_byte($sformatf("rx_bytes[%0d]", i), rx_bytes[i], exp_bytes[i]);
            // long enough for a spurious start to show up
            repeat ($urandom_range(24, 12)) begin
                @(negedge clk);
                check_bit("send_ack", send_ack, 1'b1);
            end
        end
        send_req = 1'b0;
        @(negedge clk);
        check_bit("send_ack", send_ack, 1'b0);
        check_byte("frame_count", frame_count, frames_before + 8'd1);
        if (errors != errors_before)
            failed_tests++;
        $display("test %0d: y=%h vy=%h nack_at=%0d %s", t, b.y, b.vy, k,
                 (errors == errors_before) ? "ok" : "FAILED");
    endtask

    initial begin
        int count;
        int i;
        void'($urandom(32'h1b80));
        reset = 1'b1;
        send_req = 1'b0;
        ball = '0;
        nack_at = '0;
        for (i = 0; i < 3 * MAX_TESTS; i++)
            vectors[i] = 16'h8000 | 16'(i);  // bit 15 marks an unused slot
        $readmemh("test/ball_link_testdata.txt", vectors);
        count = 0;
        while (count < MAX_TESTS && !vectors[3*count][15])
            count++;
        num_tests = count;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_bit("scl", scl, 1'b1);
        check_bit("sda_oe", sda_oe, 1'b0);
        check_bit("send_ack", send_ack, 1'b0);
        $display("idle after reset: %s", (errors == 0) ? "ok" : "FAILED");
        if (num_tests == 0)
            report_failure("no test vectors were read from the data file");
        for (i = 0; i < num_tests; i++)
            run_frame(i);
        $display("%0d tests run, %0d failed, %0d errors", num_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (num_tests > 0);
        repeat (num_tests * TEST_CLKS + 20) @(posedge clk);
        $display("watchdog expired before all tests finished");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/ball_link_testdata.txt
// columns: ball_y ball_vy nack_at, all hex
// nack_at is the 1-based byte the slave refuses, 0 when every byte is acked
000 00 0
3ff 7f 0
3ff 80 0
155 2a 0
0c8 f6 0
2a7 05 1
13b 81 2
201 33 3
0ff c0 4
3c0 01 0
07e fe 0
333 55 2
100 80 0
2aa 7f 0

// File: verilog.f
src/ball_link_pkg.sv
src/ball_frame_sequencer.sv
src/i2c_byte_master.sv
src/ball_link_top.sv
test/i2c_slave_model.sv
test/tb_ball_link.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the ball link testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_ball_link \
    --Mdir obj_dir \
    -f verilog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_ball_link)
sim_status=$?
echo "$output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$output" | grep -qx "=== PASS ==="; then
    exit 0
fi
exit 1
